/* verilog.f */
debug_pkg.sv
uart_rx.sv
uart_tx.sv
mips_lite_core.sv
debug_unit.sv
debug_top.sv
debug_top_checker.sv
tb_debug_top.sv

/* Makefile */
TOP = tb_debug_top

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f verilog.f

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean

/* tb_debug_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_debug_top;
	import debug_pkg::*;

	// program lengths without the closing halt
	localparam int len_a = 20;
	localparam int len_b = 10;
	localparam int len_c = 20;
	localparam int len_d = 6;
	// one uart frame in ns at a 4 ns clock
	localparam int byte_ns = 10 * clks_per_bit * 4;
	// each run or step is a command byte plus 40 dump bytes
	localparam int total_bytes = (2 + 4 * (len_a + 1)) + 41
		+ (2 + 4 * (len_b + 1)) + 41
		+ (2 + 4 * (len_c + 1)) + 3 * 41
		+ (1 + 6 + 41)
		+ (2 + 4 * (len_d + 1)) + 41;
	localparam int watchdog_ns = 2 * total_bytes * byte_ns + 20000;
	// cycles allowed before a dump byte starts
	localparam int start_wait = 40 * clks_per_bit;

	logic clk;
	logic rst;
	logic rx;
	logic tx;

	integer seed;
	int     error_count;
	int     check_count;
	int     test_count;
	int     failed_tests;
	int     errors_at_start;
	logic   link_ok;

	// reference model state
	logic [data_w-1:0] model_imem [2**imem_addr_w];
	logic [data_w-1:0] model_regs [num_regs];
	logic [data_w-1:0] model_pc;
	logic [data_w-1:0] model_cnt;
	logic              model_halted;
	// last dump decoded from tx
	logic [data_w-1:0] dump_got [dump_words];

	debug_top dut_i (
		.clk (clk),
		.rst (rst),
		.rx  (rx),
		.tx  (tx)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// checks and reporting
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [data_w-1:0] got,
		input logic [data_w-1:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("ERR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_failure(input string msg);
		error_count++;
		link_ok = 1'b0;
		$display("%s", msg);
	endtask

	function automatic void begin_test();
		errors_at_start = error_count;
		test_count++;
	endfunction

	task automatic end_test(input string name);
		if (error_count == errors_at_start) begin
			$display("test %0d %s: ok", test_count, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: failed with %0d errors", test_count, name,
				error_count - errors_at_start);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic void clear_model();
		for (int i = 0; i < num_regs; i++)
			model_regs[i] = '0;
		model_pc     = '0;
		model_cnt    = '0;
		model_halted = 1'b0;
	endfunction

	// one enabled cycle
	function automatic void step_model();
		instr_t            ins;
		logic [data_w-1:0] a;
		logic [data_w-1:0] b;
		logic [data_w-1:0] res;
		logic              wr;
		ins = model_imem[model_pc[imem_addr_w-1:0]];
		a   = model_regs[ins.r_form.rs];
		b   = model_regs[ins.r_form.rt];
		res = '0;
		wr  = 1'b1;
		case (ins.r_form.opcode)
			op_add:  res = a + b;
			op_sub:  res = a - b;
			op_and:  res = a & b;
			op_or:   res = a | b;
			op_addi: res = model_regs[ins.i_form.rs] + {{16{ins.i_form.imm[15]}}, ins.i_form.imm};
			default: wr = 1'b0;
		endcase
		if (ins.r_form.opcode == op_halt) begin
			// only the first halt fetch counts
			if (!model_halted) begin
				model_cnt    = model_cnt + 1;
				model_halted = 1'b1;
			end
		end else begin
			// r0 never written
			if (wr && ins.r_form.rd != '0)
				model_regs[ins.r_form.rd] = res;
			model_pc  = model_pc + 1;
			model_cnt = model_cnt + 1;
		end
	endfunction

	function automatic void run_model();
		int guard;
		clear_model();
		guard = 0;
		while (!model_halted && guard < 2**imem_addr_w + 2) begin
			step_model();
			guard++;
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// program generation
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [data_w-1:0] random_instr(input logic to_r0);
		instr_t ins;
		int     pick;
		ins  = '0;
		pick = int'({$random(seed)} % 5);
		if (pick == 4) begin
			ins.i_form.opcode = op_addi;
			ins.i_form.rd     = reg_w'($random(seed));
			ins.i_form.rs     = reg_w'($random(seed));
			ins.i_form.imm    = 16'($random(seed));
		end else begin
			case (pick)
				0:       ins.r_form.opcode = op_add;
				1:       ins.r_form.opcode = op_sub;
				2:       ins.r_form.opcode = op_and;
				default: ins.r_form.opcode = op_or;
			endcase
			ins.r_form.rd = reg_w'($random(seed));
			ins.r_form.rs = reg_w'($random(seed));
			ins.r_form.rt = reg_w'($random(seed));
		end
		// aim the write at r0
		if (to_r0)
			ins.r_form.rd = '0;
		return ins;
	endfunction

	// n random words then a halt
	function automatic void build_program(input int n, input logic r0_heavy);
		instr_t halt_word;
		for (int i = 0; i < n; i++)
			model_imem[i] = random_instr(r0_heavy && (i % 2 == 0));
		halt_word               = '0;
		halt_word.r_form.opcode = op_halt;
		model_imem[n]           = halt_word;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// serial link
	////////////////////////////////////////////////////////////////////////////

	// start, 8 data lsb first, stop
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			rx = frame[i];
			repeat (clks_per_bit - 1) @(negedge clk);
		end
	endtask

	task automatic recv_byte(output logic [7:0] b);
		int   waited;
		logic started;
		b       = '0;
		started = 1'b0;
		waited  = 0;
		while (!started && waited < start_wait) begin
			@(negedge clk);
			if (tx == 1'b0)
				started = 1'b1;
			else
				waited++;
		end
		if (!started) begin
			report_failure($sformatf("no start bit on tx within %0d cycles", start_wait));
		end else begin
			// middle of the start bit, then one bit period per sample
			repeat (clks_per_bit / 2 - 1) @(negedge clk);
			for (int i = 0; i < 8; i++) begin
				repeat (clks_per_bit) @(negedge clk);
				b[i] = tx;
			end
			repeat (clks_per_bit) @(negedge clk);
			if (tx !== 1'b1)
				report_failure("stop bit on tx was not high");
		end
	endtask

	// 40 bytes, little endian words
	task automatic recv_dump();
		logic [7:0] b;
		link_ok = 1'b1;
		for (int w = 0; w < dump_words; w++) begin
			for (int k = 0; k < 4; k++) begin
				if (link_ok) begin
					recv_byte(b);
					dump_got[w][8*k +: 8] = b;
				end
			end
		end
	endtask

	task automatic expect_quiet(input int cycles);
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk);
			if (tx == 1'b0)
				seen = 1'b1;
		end
		if (seen)
			report_failure("start bit on tx after an unknown command");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// command sequences
	////////////////////////////////////////////////////////////////////////////

	task automatic load_program(input int n_words);
		logic [data_w-1:0] w;
		send_byte(cmd_load);
		send_byte(8'(n_words));
		for (int i = 0; i < n_words; i++) begin
			w = model_imem[i];
			for (int k = 0; k < 4; k++)
				send_byte(w[8*k +: 8]);
		end
		// load also clears the core
		clear_model();
	endtask

	task automatic compare_dump();
		for (int w = 0; w < num_regs; w++)
			check_value($sformatf("r%0d", w), dump_got[w], model_regs[w]);
		check_value("pc", dump_got[num_regs], model_pc);
		check_value("cycle_count", dump_got[num_regs + 1], model_cnt);
	endtask

	task automatic run_and_compare();
		send_byte(cmd_run);
		run_model();
		recv_dump();
		if (link_ok)
			compare_dump();
	endtask

	task automatic step_and_compare();
		send_byte(cmd_step);
		step_model();
		recv_dump();
		if (link_ok)
			compare_dump();
	endtask

	// run time limit
	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, tests did not complete", watchdog_ns);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin : main
		int assert_fails;
		seed            = 32'h2a5c;
		error_count     = 0;
		check_count     = 0;
		test_count      = 0;
		failed_tests    = 0;
		errors_at_start = 0;
		link_ok         = 1'b1;
		rst             = 1'b1;
		rx              = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (4) @(negedge clk);

		begin_test();
		build_program(len_a, 1'b0);
		load_program(len_a + 1);
		run_and_compare();
		end_test("random program run");

		// every other write goes to r0
		begin_test();
		build_program(len_b, 1'b1);
		load_program(len_b + 1);
		run_and_compare();
		if (link_ok)
			check_value("r0", dump_got[0], '0);
		end_test("r0 stays zero");

		begin_test();
		build_program(len_c, 1'b0);
		load_program(len_c + 1);
		for (int s = 0; s < 3; s++) begin
			step_and_compare();
			// one instruction per step from a cleared pc
			if (link_ok)
				check_value("pc", dump_got[num_regs], data_w'(s + 1));
		end
		end_test("single steps");

		// 60 bit periods of silence
		begin_test();
		send_byte(8'h58);
		expect_quiet(60 * clks_per_bit);
		run_and_compare();
		end_test("unknown command ignored");

		begin_test();
		build_program(len_d, 1'b0);
		load_program(len_d + 1);
		run_and_compare();
		if (link_ok)
			check_value("cycle_count", dump_got[num_regs + 1], len_d + 1);
		end_test("reload shorter program");

		assert_fails = dut_i.core_i.core_chk_i.fail_count
			+ dut_i.uart_tx_i.tx_chk_i.fail_count;
		$display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			test_count, failed_tests, check_count, error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* debug_top_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_top_checker (
	input logic                         clk,
	input logic                         rst,
	// core side
	input logic                         halt,
	input logic                         core_clear,
	input logic [debug_pkg::data_w-1:0] pc,
	// transmitter side
	input logic                         tx,
	input logic                         tx_busy,
	input logic                         tx_start
);
	// number of assertion failures so far
	int unsigned fail_count = 0;

	// halt freezes pc, only a clear moves it
	pc_hold: assert property (@(posedge clk) disable iff (rst)
		(halt && !core_clear) |=> (pc == $past(pc)))
	else begin
		$error("pc changed while halt was high");
		fail_count++;
	end

	// idle line stays at the stop level
	tx_idle_high: assert property (@(posedge clk) disable iff (rst)
		!tx_busy |-> tx)
	else begin
		$error("tx low while the transmitter was idle");
		fail_count++;
	end

	// no new byte while one is on the wire
	no_start_when_busy: assert property (@(posedge clk) disable iff (rst)
		tx_busy |-> !tx_start)
	else begin
		$error("tx_start raised while tx_busy was high");
		fail_count++;
	end

endmodule

// core instance, transmitter inputs tied quiet
bind mips_lite_core debug_top_checker core_chk_i (
	.clk        (clk),
	.rst        (rst),
	.halt       (halt),
	.core_clear (core_clear),
	.pc         (pc),
	.tx         (1'b1),
	.tx_busy    (1'b0),
	.tx_start   (1'b0)
);

// transmitter instance, core inputs tied quiet
bind uart_tx debug_top_checker tx_chk_i (
	.clk        (clk),
	.rst        (rst),
	.halt       (1'b0),
	.core_clear (1'b0),
	.pc         ('0),
	.tx         (tx),
	.tx_busy    (tx_busy),
	.tx_start   (tx_start)
);

`default_nettype wire

/* debug_top.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_top (
	input  logic clk,
	input  logic rst,
	input  logic rx,
	output logic tx
);
	import debug_pkg::*;

	// uart side
	logic [7:0] rx_data;
	logic       rx_done;
	logic [7:0] tx_data;
	logic       tx_start;
	logic       tx_busy;
	logic       tx_done;

	// core side
	logic                   imem_we;
	logic [imem_addr_w-1:0] imem_addr;
	logic [data_w-1:0]      imem_wdata;
	logic                   core_clear;
	logic                   run_en;
	logic [3:0]             dump_sel;
	logic                   halt;
	logic [data_w-1:0]      dump_word;

	uart_rx uart_rx_i (
		.clk     (clk),
		.rst     (rst),
		.rx      (rx),
		.rx_data (rx_data),
		.rx_done (rx_done)
	);

	uart_tx uart_tx_i (
		.clk      (clk),
		.rst      (rst),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx       (tx),
		.tx_busy  (tx_busy),
		.tx_done  (tx_done)
	);

	debug_unit debug_unit_i (
		.clk        (clk),
		.rst        (rst),
		.rx_data    (rx_data),
		.rx_done    (rx_done),
		.tx_busy    (tx_busy),
		.tx_done    (tx_done),
		.halt       (halt),
		.dump_word  (dump_word),
		.tx_data    (tx_data),
		.tx_start   (tx_start),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.core_clear (core_clear),
		.run_en     (run_en),
		.dump_sel   (dump_sel)
	);

	mips_lite_core core_i (
		.clk        (clk),
		.rst        (rst),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.core_clear (core_clear),
		.run_en     (run_en),
		.dump_sel   (dump_sel),
		.halt       (halt),
		.dump_word  (dump_word)
	);

endmodule

`default_nettype wire

/* debug_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_unit (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [7:0]                       rx_data,
	input  logic                             rx_done,
	input  logic                             tx_busy,
	input  logic                             tx_done,
	input  logic                             halt,
	input  logic [debug_pkg::data_w-1:0]      dump_word,
	output logic [7:0]                       tx_data,
	output logic                             tx_start,
	output logic                             imem_we,
	output logic [debug_pkg::imem_addr_w-1:0] imem_addr,
	output logic [debug_pkg::data_w-1:0]      imem_wdata,
	output logic                             core_clear,
	output logic                             run_en,
	output logic [3:0]                       dump_sel
);
	import debug_pkg::*;

	logic [2:0]  state;
	// program load
	logic [7:0]  words_left;
	logic [1:0]  byte_idx;
	logic [23:0] wbuf;
	// dump walk
	logic [1:0]  dump_byte;
	logic        tx_req;

	// run waits out the clear cycle, step is a single cycle
	assign run_en = ((state == st_run) && !core_clear) || (state == st_step);

	// little endian byte of the selected word
	assign tx_data = dump_word[{dump_byte, 3'b000} +: 8];

	////////////////////////////////////////////////////////////////////////////
	// command fsm
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= st_idle;
			imem_we    <= 1'b0;
			imem_addr  <= '0;
			core_clear <= 1'b0;
			tx_start   <= 1'b0;
			tx_req     <= 1'b0;
			words_left <= '0;
			byte_idx   <= '0;
			dump_sel   <= '0;
			dump_byte  <= '0;
		end else begin
			// one cycle strobes
			imem_we    <= 1'b0;
			core_clear <= 1'b0;
			tx_start   <= 1'b0;
			// step address after each write
			if (imem_we)
				imem_addr <= imem_addr + 1'b1;

			case (state)
				st_idle: begin
					if (rx_done) begin
						case (rx_data)
							cmd_load: state <= st_get_count;
							cmd_run: begin
								core_clear <= 1'b1;
								state      <= st_run;
							end
							cmd_step: state <= st_step;
							// anything else is dropped
							default: state <= st_idle;
						endcase
					end
				end

				st_get_count: begin
					if (rx_done) begin
						imem_addr  <= '0;
						words_left <= rx_data;
						byte_idx   <= '0;
						if (rx_data == 8'd0) begin
							core_clear <= 1'b1;
							state      <= st_idle;
						end else begin
							state <= st_get_bytes;
						end
					end
				end

				st_get_bytes: begin
					if (rx_done) begin
						byte_idx <= byte_idx + 1'b1;
						// fourth byte completes the word
						if (byte_idx == 2'd3) begin
							imem_we    <= 1'b1;
							words_left <= words_left - 1'b1;
							if (words_left == 8'd1) begin
								core_clear <= 1'b1;
								state      <= st_idle;
							end
						end
					end
				end

				st_run: begin
					// halt from the cleared pc only
					if (!core_clear && halt) begin
						state     <= st_dump;
						tx_req    <= 1'b1;
						dump_sel  <= '0;
						dump_byte <= '0;
					end
				end

				st_step: begin
					state     <= st_dump;
					tx_req    <= 1'b1;
					dump_sel  <= '0;
					dump_byte <= '0;
				end

				st_dump: begin
					// launch pending byte once uart is free
					if (tx_req && !tx_busy) begin
						tx_start <= 1'b1;
						tx_req   <= 1'b0;
					end
					if (tx_done) begin
						if (dump_byte == 2'd3) begin
							dump_byte <= '0;
							if (dump_sel == 4'(dump_words - 1)) begin
								state <= st_idle;
							end else begin
								dump_sel <= dump_sel + 1'b1;
								tx_req   <= 1'b1;
							end
						end else begin
							dump_byte <= dump_byte + 1'b1;
							tx_req    <= 1'b1;
						end
					end
				end

				default: state <= st_idle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// word assembly
	////////////////////////////////////////////////////////////////////////////

	// first byte ends up lowest
	always_ff @(posedge clk) begin
		if (state == st_get_bytes && rx_done) begin
			wbuf       <= {rx_data, wbuf[23:8]};
			imem_wdata <= {rx_data, wbuf};
		end
	end

endmodule

`default_nettype wire

/* mips_lite_core.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_lite_core (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             imem_we,
	input  logic [debug_pkg::imem_addr_w-1:0] imem_addr,
	input  logic [debug_pkg::data_w-1:0]      imem_wdata,
	input  logic                             core_clear,
	input  logic                             run_en,
	input  logic [3:0]                       dump_sel,
	output logic                             halt,
	output logic [debug_pkg::data_w-1:0]      dump_word
);
	import debug_pkg::*;

	logic [data_w-1:0] imem [2**imem_addr_w];
	logic [data_w-1:0] regs [num_regs];
	logic [data_w-1:0] pc;
	logic [data_w-1:0] cycle_cnt;
	// halt already counted once
	logic              halt_seen;

	instr_t            instr;
	logic [data_w-1:0] rs_val;
	logic [data_w-1:0] rt_val;
	logic [data_w-1:0] imm_ext;
	logic [data_w-1:0] result;
	logic              wr_en;
	logic              exec;

	// program memory, host writes only
	always_ff @(posedge clk) begin
		if (imem_we)
			imem[imem_addr] <= imem_wdata;
	end

	////////////////////////////////////////////////////////////////////////////
	// fetch and decode
	////////////////////////////////////////////////////////////////////////////

	// async read, pc wraps over the memory
	assign instr = imem[pc[imem_addr_w-1:0]];
	assign halt  = (instr.r_form.opcode == op_halt);
	assign exec  = run_en && !halt;

	// source a is at the same spot in both forms
	assign rs_val  = regs[instr.r_form.rs];
	assign rt_val  = regs[instr.r_form.rt];
	assign imm_ext = {{(data_w - 16){instr.i_form.imm[15]}}, instr.i_form.imm};

	always_comb begin
		result = '0;
		wr_en  = 1'b0;
		case (instr.r_form.opcode)
			op_add: begin
				result = rs_val + rt_val;
				wr_en  = 1'b1;
			end
			op_sub: begin
				result = rs_val - rt_val;
				wr_en  = 1'b1;
			end
			op_and: begin
				result = rs_val & rt_val;
				wr_en  = 1'b1;
			end
			op_or: begin
				result = rs_val | rt_val;
				wr_en  = 1'b1;
			end
			op_addi: begin
				result = regs[instr.i_form.rs] + imm_ext;
				wr_en  = 1'b1;
			end
			// halt and unknown opcodes write nothing
			default: begin
				result = '0;
				wr_en  = 1'b0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// architectural state
	////////////////////////////////////////////////////////////////////////////

	// r0 is cleared and never written, so it reads zero
	always_ff @(posedge clk) begin
		if (rst || core_clear) begin
			for (int i = 0; i < num_regs; i++)
				regs[i] <= '0;
		end else if (exec && wr_en && instr.r_form.rd != '0) begin
			regs[instr.r_form.rd] <= result;
		end
	end

	// pc holds on halt, count takes the first halt fetch too
	always_ff @(posedge clk) begin
		if (rst || core_clear) begin
			pc        <= '0;
			cycle_cnt <= '0;
			halt_seen <= 1'b0;
		end else if (run_en) begin
			if (!halt) begin
				pc        <= pc + 1'b1;
				cycle_cnt <= cycle_cnt + 1'b1;
			end else if (!halt_seen) begin
				cycle_cnt <= cycle_cnt + 1'b1;
				halt_seen <= 1'b1;
			end
		end
	end

	// dump select, regs then pc then count
	always_comb begin
		if (dump_sel < 4'(num_regs))
			dump_word = regs[dump_sel[reg_w-1:0]];
		else if (dump_sel == 4'(num_regs))
			dump_word = pc;
		else if (dump_sel == 4'(num_regs + 1))
			dump_word = cycle_cnt;
		else
			dump_word = '0;
	end

endmodule

`default_nettype wire

/* uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input  logic       clk,
	input  logic       rst,
	input  logic       tx_start,
	input  logic [7:0] tx_data,
	output logic       tx,
	output logic       tx_busy,
	output logic       tx_done
);
	import debug_pkg::*;

	// 0 start, 1..8 data, 9 stop
	logic [3:0]           bit_idx;
	logic [bit_cnt_w-1:0] cnt;
	// stop bit above the data byte
	logic [8:0]           shreg;
	logic                 bit_tick;

	assign bit_tick = (cnt == bit_cnt_w'(clks_per_bit - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			tx      <= 1'b1;
			tx_busy <= 1'b0;
			tx_done <= 1'b0;
			bit_idx <= '0;
			cnt     <= '0;
		end else begin
			tx_done <= 1'b0;
			if (!tx_busy) begin
				cnt     <= '0;
				bit_idx <= '0;
				if (tx_start) begin
					tx_busy <= 1'b1;
					// start bit
					tx <= 1'b0;
				end
			end else if (bit_tick) begin
				cnt <= '0;
				if (bit_idx == 4'd9) begin
					// end of stop bit, line already high
					tx_busy <= 1'b0;
					tx_done <= 1'b1;
				end else begin
					tx      <= shreg[0];
					bit_idx <= bit_idx + 1'b1;
				end
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// byte latched on start, shifted out lsb first
	always_ff @(posedge clk) begin
		if (!tx_busy && tx_start)
			shreg <= {1'b1, tx_data};
		else if (tx_busy && bit_tick && bit_idx != 4'd9)
			shreg <= {1'b1, shreg[8:1]};
	end

endmodule

`default_nettype wire

/* uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input  logic       clk,
	input  logic       rst,
	input  logic       rx,
	output logic [7:0] rx_data,
	output logic       rx_done
);
	import debug_pkg::*;

	// two flop synchronizer
	logic rx_meta;
	logic rx_sync;

	// frame position, 0 start, 1..8 data, 9 stop
	logic                 busy;
	logic [3:0]           bit_idx;
	logic [bit_cnt_w-1:0] cnt;
	logic [7:0]           shreg;

	logic half_tick;
	logic bit_tick;
	logic sample_data;
	logic sample_stop;

	assign half_tick   = (cnt == bit_cnt_w'(clks_per_bit / 2 - 1));
	assign bit_tick    = (cnt == bit_cnt_w'(clks_per_bit - 1));
	assign sample_data = busy && (bit_idx != 4'd0) && (bit_idx != 4'd9) && bit_tick;
	assign sample_stop = busy && (bit_idx == 4'd9) && bit_tick;

	// line idles high
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// bit timing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			busy    <= 1'b0;
			bit_idx <= '0;
			cnt     <= '0;
			rx_done <= 1'b0;
		end else begin
			rx_done <= 1'b0;
			if (!busy) begin
				cnt     <= '0;
				bit_idx <= '0;
				// falling edge, possible start bit
				if (!rx_sync)
					busy <= 1'b1;
			end else if (bit_idx == 4'd0) begin
				// recheck start at its middle
				if (half_tick) begin
					cnt <= '0;
					if (rx_sync)
						busy <= 1'b0;
					else
						bit_idx <= 4'd1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end else if (bit_tick) begin
				cnt <= '0;
				if (bit_idx == 4'd9) begin
					busy <= 1'b0;
					// bad stop bit, no strobe
					rx_done <= rx_sync;
				end else begin
					bit_idx <= bit_idx + 1'b1;
				end
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// lsb first, shift in from the top
	always_ff @(posedge clk) begin
		if (sample_data)
			shreg <= {rx_sync, shreg[7:1]};
		if (sample_stop && rx_sync)
			rx_data <= shreg;
	end

endmodule

`default_nettype wire

/* debug_pkg.sv */
`default_nettype none

package debug_pkg;

	////////////////////////////////////////////////////////////////////////////
	// sizes
	////////////////////////////////////////////////////////////////////////////

	// datapath and instruction word
	localparam int data_w      = 32;
	localparam int num_regs    = 8;
	localparam int reg_w       = $clog2(num_regs);
	// 128 words of program memory
	localparam int imem_addr_w = 7;
	// short bit period for simulation
	localparam int clks_per_bit = 8;
	localparam int bit_cnt_w    = $clog2(clks_per_bit) + 1;
	// 8 regs, pc, cycle count
	localparam int dump_words   = 10;

	// opcodes
	localparam logic [5:0] op_add  = 6'h01;
	localparam logic [5:0] op_sub  = 6'h02;
	localparam logic [5:0] op_and  = 6'h03;
	localparam logic [5:0] op_or   = 6'h04;
	localparam logic [5:0] op_addi = 6'h08;
	localparam logic [5:0] op_halt = 6'h3f;

	// host command bytes, ascii
	localparam logic [7:0] cmd_load = 8'h4c;
	localparam logic [7:0] cmd_run  = 8'h52;
	localparam logic [7:0] cmd_step = 8'h53;

	// debug unit fsm codes
	localparam logic [2:0] st_idle      = 3'd0;
	localparam logic [2:0] st_get_count = 3'd1;
	localparam logic [2:0] st_get_bytes = 3'd2;
	localparam logic [2:0] st_run       = 3'd3;
	localparam logic [2:0] st_step      = 3'd4;
	localparam logic [2:0] st_dump      = 3'd5;

	////////////////////////////////////////////////////////////////////////////
	// instruction word, register form and immediate form
	////////////////////////////////////////////////////////////////////////////

	// opcode sits in the top six bits of both views
	typedef union packed {
		struct packed {
			logic [5:0]                          opcode;
			logic [reg_w-1:0]                    rd;
			logic [reg_w-1:0]                    rs;
			logic [reg_w-1:0]                    rt;
			logic [data_w-6-3*reg_w-1:0]         unused;
		} r_form;
		struct packed {
			logic [5:0]                          opcode;
			logic [reg_w-1:0]                    rd;
			logic [reg_w-1:0]                    rs;
			logic [data_w-6-2*reg_w-16-1:0]      pad;
			logic [15:0]                         imm;
		} i_form;
	} instr_t;

endpackage

`default_nettype wire
